// File: hdl/dram_traffic_pkg.sv
package dram_traffic_pkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 128;

    // DRAM word address and one DRAM data word
    typedef logic [ADDR_W-1:0] dram_addr_t;
    typedef logic [DATA_W-1:0] dram_data_t;

    // 153-bit request to the memory controller
    typedef struct packed {
        dram_addr_t addr;
        logic       is_write;
        dram_data_t write_data;
    } mem_request_t;

    // What the command queue keeps for each issued request in 25 bits
    typedef struct packed {
        dram_addr_t addr;
        logic       is_write;
    } pending_cmd_t;

    // 152-bit audio response word with its address attached
    typedef struct packed {
        dram_addr_t addr;
        dram_data_t data;
    } audio_read_t;

    // Request slot of the traffic generator
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_WR_AUDIO,
        GEN_WR_VIDEO,
        GEN_RD_AUDIO,
        GEN_RD_VIDEO
    } gen_state_t;

endpackage

// File: hdl/command_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module command_fifo #(
    parameter int DEPTH = 64
) (
    input  logic                          clk_dram_ctrl,
    input  logic                          rst_dram_ctrl,
    input  logic                          push,
    input  dram_traffic_pkg::pending_cmd_t push_cmd,
    input  logic                          pop,
    output dram_traffic_pkg::pending_cmd_t head_cmd
);
    import dram_traffic_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pending_cmd_t     cmd_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] result;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + PTR_W'(1);
        end
        return result;
    endfunction

    always_ff @(posedge clk_dram_ctrl) begin
        if (push) begin
            cmd_mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // Oldest outstanding command is seen without a read cycle
    assign head_cmd = cmd_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/traffic_generator.sv
`timescale 1ns/100ps
`default_nettype none

module traffic_generator #(
    parameter int FRAME_BUFFER_DEPTH = 115200
) (
    input  logic                          clk_dram_ctrl,
    input  logic                          rst_dram_ctrl,
    input  dram_traffic_pkg::dram_data_t  write_data,
    input  logic                          write_last,
    input  logic                          write_valid,
    output logic                          write_ready,
    input  dram_traffic_pkg::dram_addr_t  read_addr,
    input  logic                          read_addr_valid,
    output logic                          read_addr_ready,
    input  logic                          video_almost_full,
    input  logic                          mem_busy,
    output dram_traffic_pkg::mem_request_t mem_request,
    output logic                          mem_request_en,
    output dram_traffic_pkg::dram_addr_t  audio_last_addr,
    output logic                          boundary_valid,
    input  logic                          last_audio_acked,
    output logic                          sample_load_complete
);
    import dram_traffic_pkg::*;

    gen_state_t state;
    gen_state_t state_next;
    dram_addr_t write_addr;
    dram_addr_t video_rd_addr;
    dram_addr_t frame_base;
    dram_addr_t frame_top;
    logic       write_fire;
    logic       video_rd_fire;
    logic       capture_boundary;

    // Frame buffer spans boundary+1 up to boundary+FRAME_BUFFER_DEPTH
    assign frame_base = audio_last_addr + dram_addr_t'(1);
    assign frame_top  = audio_last_addr + dram_addr_t'(FRAME_BUFFER_DEPTH);

    assign write_ready     = !mem_busy && ((state == GEN_WR_AUDIO) || (state == GEN_WR_VIDEO));
    assign read_addr_ready = !mem_busy && (state == GEN_RD_AUDIO);

    assign write_fire       = write_valid && write_ready;
    assign video_rd_fire    = (state == GEN_RD_VIDEO) && !video_almost_full && !mem_busy;
    assign capture_boundary = write_fire && write_last && !boundary_valid;

    // Stay in the audio write slot until the last audio word is acknowledged
    always_comb begin
        if (!sample_load_complete) begin
            state_next = GEN_WR_AUDIO;
        end else begin
            case (state)
                GEN_RD_AUDIO: state_next = GEN_WR_VIDEO;
                GEN_WR_VIDEO: state_next = GEN_RD_VIDEO;
                GEN_RD_VIDEO: state_next = GEN_RD_AUDIO;
                default:      state_next = GEN_RD_AUDIO;
            endcase
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state <= GEN_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            audio_last_addr <= '0;
            boundary_valid  <= 1'b0;
        end else if (capture_boundary) begin
            audio_last_addr <= write_addr;
            boundary_valid  <= 1'b1;
        end
    end

    // Audio addresses count up from 0, video addresses wrap in the ring
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            write_addr <= '0;
        end else if (write_fire) begin
            if (write_last && boundary_valid) begin
                write_addr <= frame_base;
            end else if (boundary_valid && (write_addr == frame_top)) begin
                write_addr <= frame_base;
            end else begin
                write_addr <= write_addr + dram_addr_t'(1);
            end
        end
    end

    // Video read pointer starts at the frame base once the boundary is known
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            video_rd_addr <= '0;
        end else if (capture_boundary) begin
            video_rd_addr <= write_addr + dram_addr_t'(1);
        end else if (video_rd_fire) begin
            if (video_rd_addr == frame_top) begin
                video_rd_addr <= frame_base;
            end else begin
                video_rd_addr <= video_rd_addr + dram_addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            sample_load_complete <= 1'b0;
        end else if (last_audio_acked) begin
            sample_load_complete <= 1'b1;
        end
    end

    // One request source per slot
    always_comb begin
        mem_request    = '0;
        mem_request_en = 1'b0;
        case (state)
            GEN_WR_AUDIO, GEN_WR_VIDEO: begin
                mem_request.addr       = write_addr;
                mem_request.is_write   = 1'b1;
                mem_request.write_data = write_data;
                mem_request_en         = write_fire;
            end
            GEN_RD_AUDIO: begin
                mem_request.addr = read_addr;
                mem_request_en   = read_addr_valid && !mem_busy;
            end
            GEN_RD_VIDEO: begin
                mem_request.addr = video_rd_addr;
                mem_request_en   = video_rd_fire;
            end
            default: begin
                mem_request_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/response_router.sv
`timescale 1ns/100ps
`default_nettype none

module response_router #(
    parameter int FRAME_BUFFER_DEPTH = 115200,
    parameter int CMD_FIFO_DEPTH     = 64
) (
    input  logic                           clk_dram_ctrl,
    input  logic                           rst_dram_ctrl,
    input  dram_traffic_pkg::mem_request_t mem_request,
    input  logic                           mem_request_en,
    input  logic                           mem_complete,
    input  dram_traffic_pkg::dram_data_t   mem_resp_data,
    input  dram_traffic_pkg::dram_addr_t   audio_last_addr,
    input  logic                           boundary_valid,
    output logic                           audio_valid,
    output dram_traffic_pkg::audio_read_t  audio_data,
    output logic                           video_valid,
    output dram_traffic_pkg::dram_data_t   video_data,
    output logic                           video_last,
    output logic                           last_audio_acked
);
    import dram_traffic_pkg::*;

    pending_cmd_t push_cmd;
    pending_cmd_t head_cmd;
    dram_addr_t   frame_base;
    dram_addr_t   frame_top;
    logic         resp_is_video;
    logic         resp_is_read;

    assign push_cmd.addr     = mem_request.addr;
    assign push_cmd.is_write = mem_request.is_write;

    // Completions come back in issue order, so the head matches each one
    command_fifo #(
        .DEPTH(CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .push         (mem_request_en),
        .push_cmd     (push_cmd),
        .pop          (mem_complete),
        .head_cmd     (head_cmd)
    );

    assign frame_base = audio_last_addr + dram_addr_t'(1);
    assign frame_top  = audio_last_addr + dram_addr_t'(FRAME_BUFFER_DEPTH);

    assign resp_is_read  = mem_complete && !head_cmd.is_write;
    assign resp_is_video = boundary_valid && (head_cmd.addr >= frame_base) &&
                           (head_cmd.addr <= frame_top);

    assign audio_valid     = resp_is_read && !resp_is_video;
    assign audio_data.addr = head_cmd.addr;
    assign audio_data.data = mem_resp_data;

    assign video_valid = resp_is_read && resp_is_video;
    assign video_data  = mem_resp_data;
    assign video_last  = video_valid && (head_cmd.addr == frame_top);

    // Only the write of the last audio word ends the sample load
    assign last_audio_acked = mem_complete && head_cmd.is_write && boundary_valid &&
                              (head_cmd.addr == audio_last_addr);

endmodule

`default_nettype wire

// File: hdl/dram_traffic_top.sv
`timescale 1ns/100ps
`default_nettype none

module dram_traffic_top #(
    parameter int FRAME_BUFFER_DEPTH = 115200,
    parameter int CMD_FIFO_DEPTH     = 64
) (
    input  logic                           clk_dram_ctrl,
    input  logic                           rst_dram_ctrl,

    // Memory controller
    output dram_traffic_pkg::mem_request_t mem_request,
    output logic                           mem_request_en,
    input  logic                           mem_busy,
    input  logic                           mem_complete,
    input  dram_traffic_pkg::dram_data_t   mem_resp_data,

    // Write stream
    input  dram_traffic_pkg::dram_data_t   write_data,
    input  logic                           write_last,
    input  logic                           write_valid,
    output logic                           write_ready,

    // Read-address stream for audio
    input  dram_traffic_pkg::dram_addr_t   read_addr,
    input  logic                           read_addr_valid,
    output logic                           read_addr_ready,

    // Audio out where ready has no effect on responses
    output logic                           audio_valid,
    output dram_traffic_pkg::audio_read_t  audio_data,
    input  logic                           audio_ready,

    // Video out where almost-full throttles video reads
    output logic                           video_valid,
    output dram_traffic_pkg::dram_data_t   video_data,
    output logic                           video_last,
    input  logic                           video_ready,
    input  logic                           video_almost_full,

    output logic                           sample_load_complete
);
    import dram_traffic_pkg::*;

    dram_addr_t audio_last_addr;
    logic       boundary_valid;
    logic       last_audio_acked;

    traffic_generator #(
        .FRAME_BUFFER_DEPTH(FRAME_BUFFER_DEPTH)
    ) u_traffic_generator (
        .clk_dram_ctrl       (clk_dram_ctrl),
        .rst_dram_ctrl       (rst_dram_ctrl),
        .write_data          (write_data),
        .write_last          (write_last),
        .write_valid         (write_valid),
        .write_ready         (write_ready),
        .read_addr           (read_addr),
        .read_addr_valid     (read_addr_valid),
        .read_addr_ready     (read_addr_ready),
        .video_almost_full   (video_almost_full),
        .mem_busy            (mem_busy),
        .mem_request         (mem_request),
        .mem_request_en      (mem_request_en),
        .audio_last_addr     (audio_last_addr),
        .boundary_valid      (boundary_valid),
        .last_audio_acked    (last_audio_acked),
        .sample_load_complete(sample_load_complete)
    );

    response_router #(
        .FRAME_BUFFER_DEPTH(FRAME_BUFFER_DEPTH),
        .CMD_FIFO_DEPTH    (CMD_FIFO_DEPTH)
    ) u_response_router (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .mem_request     (mem_request),
        .mem_request_en  (mem_request_en),
        .mem_complete    (mem_complete),
        .mem_resp_data   (mem_resp_data),
        .audio_last_addr (audio_last_addr),
        .boundary_valid  (boundary_valid),
        .audio_valid     (audio_valid),
        .audio_data      (audio_data),
        .video_valid     (video_valid),
        .video_data      (video_data),
        .video_last      (video_last),
        .last_audio_acked(last_audio_acked)
    );

endmodule

`default_nettype wire

// File: testbench/dram_traffic_checker.sv
`timescale 1ns/100ps

module dram_traffic_checker (
    input logic clk_dram_ctrl,
    input logic rst_dram_ctrl,
    input logic mem_request_en,
    input logic mem_busy,
    input logic audio_valid,
    input logic video_valid,
    input logic video_last,
    input logic write_valid,
    input logic read_addr_valid
);
    logic seen_valid;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            seen_valid <= 1'b0;
        end else if (write_valid || read_addr_valid) begin
            seen_valid <= 1'b1;
        end
    end

    a_no_request_when_busy: assert property (@(posedge clk_dram_ctrl)
        disable iff (rst_dram_ctrl) !(mem_request_en && mem_busy))
        else $error("Request issued while the controller is busy");

    a_one_output_at_a_time: assert property (@(posedge clk_dram_ctrl)
        disable iff (rst_dram_ctrl) !(audio_valid && video_valid))
        else $error("Audio and video responses valid together");

    a_last_needs_valid: assert property (@(posedge clk_dram_ctrl)
        disable iff (rst_dram_ctrl) video_last |-> video_valid)
        else $error("Video last without video valid");

    // Nothing may be requested before any stream has offered a beat
    a_quiet_after_reset: assert property (@(posedge clk_dram_ctrl)
        disable iff (rst_dram_ctrl)
        !(seen_valid || write_valid || read_addr_valid) |-> !mem_request_en)
        else $error("Request issued before any valid input");

endmodule

bind dram_traffic_top dram_traffic_checker u_checker (
    .clk_dram_ctrl  (clk_dram_ctrl),
    .rst_dram_ctrl  (rst_dram_ctrl),
    .mem_request_en (mem_request_en),
    .mem_busy       (mem_busy),
    .audio_valid    (audio_valid),
    .video_valid    (video_valid),
    .video_last     (video_last),
    .write_valid    (write_valid),
    .read_addr_valid(read_addr_valid)
);

// File: testbench/tb_dram_traffic.sv
`timescale 1ns/100ps

module tb_dram_traffic;
    import dram_traffic_pkg::*;

    localparam int FRAME_DEPTH = 12;
    localparam int AUDIO_LEN   = 5;
    localparam int VIDEO_LEN   = 15;
    localparam int VREAD_LEN   = 13;
    localparam int TABLE_LEN   = 2 * AUDIO_LEN + VIDEO_LEN + VREAD_LEN;
    localparam int CYCLE_LIMIT = TABLE_LEN * 40;

    typedef enum int {PH_AUDIO_LOAD, PH_VIDEO_FILL, PH_AUDIO_READ, PH_VIDEO_READ} phase_t;

    typedef struct {
        phase_t     phase;
        logic       last;
        dram_addr_t addr;
        dram_data_t data;
    } stim_t;

    typedef struct {
        dram_addr_t addr;
        logic       is_write;
        dram_data_t data;
        int         due;
    } pending_t;

    typedef struct packed {
        dram_data_t data;
        logic       last;
    } video_resp_t;

    logic clk_dram_ctrl;
    logic rst_dram_ctrl;
    mem_request_t mem_request;
    logic mem_request_en, mem_busy, mem_complete;
    dram_data_t mem_resp_data, write_data, video_data;
    logic write_last, write_valid, write_ready;
    dram_addr_t read_addr;
    logic read_addr_valid, read_addr_ready;
    logic audio_valid, audio_ready, video_valid, video_last, video_ready;
    logic video_almost_full, sample_load_complete;
    audio_read_t audio_data;

    stim_t        stim [TABLE_LEN];
    dram_data_t   model_mem [dram_addr_t];
    pending_t     pend_q [$];
    mem_request_t wr_log [$];
    audio_read_t  aud_log [$];
    video_resp_t  vid_log [$];
    dram_addr_t   compl_addr;
    logic         compl_is_write;
    logic [31:0]  rng;
    logic         slc_due, slc_done;
    int cycle, errors, checks, write_count, read_count, resp_count, audio_count;

    dram_traffic_top #(
        .FRAME_BUFFER_DEPTH(FRAME_DEPTH),
        .CMD_FIFO_DEPTH    (16)
    ) u_dut (.*);

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #4 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic dram_data_t make_word(input int k);
        return {32'hA0D1_0000 + 32'(k), 32'h5A5A_0000 + 32'(k), ~32'(k), 32'(k * 7)};
    endfunction

    // Video beat j lands at base plus j mod depth in the expected image
    task automatic build_table();
        dram_data_t img [int];
        int n;
        n = 0;
        for (int i = 0; i < AUDIO_LEN; i++) begin
            stim[n] = '{PH_AUDIO_LOAD, i == AUDIO_LEN - 1, dram_addr_t'(i), make_word(i)};
            n++;
        end
        for (int j = 0; j < VIDEO_LEN; j++) begin
            stim[n] = '{PH_VIDEO_FILL, 1'b0, dram_addr_t'(AUDIO_LEN + j % FRAME_DEPTH),
                        make_word(100 + j)};
            img[AUDIO_LEN + j % FRAME_DEPTH] = make_word(100 + j);
            n++;
        end
        for (int i = 0; i < AUDIO_LEN; i++) begin
            stim[n] = '{PH_AUDIO_READ, 1'b0, dram_addr_t'(i), make_word(i)};
            n++;
        end
        for (int k = 0; k < VREAD_LEN; k++) begin
            stim[n] = '{PH_VIDEO_READ, (k % FRAME_DEPTH) == FRAME_DEPTH - 1,
                        dram_addr_t'(AUDIO_LEN + k % FRAME_DEPTH),
                        img[AUDIO_LEN + k % FRAME_DEPTH]};
            n++;
        end
    endtask

    task automatic check_addr(input string name, input dram_addr_t exp, input dram_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input dram_data_t exp, input dram_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_audio(input string name, input audio_read_t exp,
                               input audio_read_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at cycle %0d: %s", cycle, what);
    endtask

    // Beats stay on the bus from a falling edge until a rising edge with ready
    task automatic send_write(input dram_data_t data, input logic last);
        bit done;
        done = 0;
        @(negedge clk_dram_ctrl);
        write_data  = data;
        write_last  = last;
        write_valid = 1'b1;
        while (!done) begin
            #2;
            done = write_ready;
            @(negedge clk_dram_ctrl);
        end
        write_valid = 1'b0;
        write_last  = 1'b0;
    endtask

    task automatic send_read_addr(input dram_addr_t addr);
        bit done;
        done = 0;
        @(negedge clk_dram_ctrl);
        read_addr       = addr;
        read_addr_valid = 1'b1;
        while (!done) begin
            #2;
            done = read_addr_ready;
            @(negedge clk_dram_ctrl);
        end
        read_addr_valid = 1'b0;
    endtask

    // DRAM model outputs change on the falling edge
    always @(negedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            mem_busy     = 1'b0;
            mem_complete = 1'b0;
        end else begin
            rng      = xorshift(rng);
            mem_busy = (rng[1:0] == 2'b00);
            if (pend_q.size() > 0 && pend_q[0].due <= cycle) begin
                mem_complete   = 1'b1;
                mem_resp_data  = pend_q[0].data;
                compl_addr     = pend_q[0].addr;
                compl_is_write = pend_q[0].is_write;
                void'(pend_q.pop_front());
            end else begin
                mem_complete = 1'b0;
            end
        end
    end

    // Requests and responses are taken on the rising edge
    always @(posedge clk_dram_ctrl) begin
        pending_t p;
        logic     in_frame;
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end else if (!rst_dram_ctrl) begin
            if (slc_due) begin
                if (!sample_load_complete) report_failure("sample_load_complete did not rise");
                slc_due  = 1'b0;
                slc_done = 1'b1;
            end else if (!slc_done && sample_load_complete) begin
                report_failure("sample_load_complete rose before the last audio write completed");
            end
            if ((write_ready || read_addr_ready) && mem_busy) report_failure("ready high while busy");
            if (mem_request_en) begin
                p = '{mem_request.addr, mem_request.is_write, mem_request.write_data, cycle + 3};
                if (mem_request.is_write) begin
                    model_mem[mem_request.addr] = mem_request.write_data;
                    wr_log.push_back(mem_request);
                    write_count++;
                end else begin
                    in_frame = mem_request.addr >= dram_addr_t'(AUDIO_LEN);
                    if (video_almost_full && in_frame) begin
                        report_failure("video read issued while almost full");
                    end
                    p.data = model_mem.exists(mem_request.addr) ? model_mem[mem_request.addr] : '0;
                    read_count++;
                end
                pend_q.push_back(p);
            end
            if (mem_complete && compl_is_write && compl_addr == dram_addr_t'(AUDIO_LEN - 1) &&
                !slc_done) begin
                slc_due = 1'b1;
            end
            if (mem_complete && !compl_is_write) begin
                in_frame = compl_addr >= dram_addr_t'(AUDIO_LEN) &&
                           compl_addr <= dram_addr_t'(AUDIO_LEN + FRAME_DEPTH - 1);
                if (video_valid !== in_frame || audio_valid !== !in_frame) begin
                    report_failure("read response steered to the wrong output");
                end
            end else if (audio_valid || video_valid) begin
                report_failure("response valid without a read completion");
            end
            if (audio_valid || video_valid) begin
                resp_count++;
            end
            if (audio_valid) begin
                aud_log.push_back(audio_data);
                audio_count++;
            end
            if (video_valid) vid_log.push_back('{video_data, video_last});
        end
    end

    initial begin
        mem_request_t wr;
        audio_read_t  ar;
        video_resp_t  vr;
        string        name;
        rng = 32'd93427;
        {cycle, errors, checks, write_count, read_count, resp_count, audio_count} = '0;
        {slc_due, slc_done} = 2'b00;
        rst_dram_ctrl = 1'b1;
        {mem_busy, mem_complete, write_last, write_valid, read_addr_valid} = '0;
        {audio_ready, video_ready} = 2'b11;
        video_almost_full = 1'b1;
        mem_resp_data = '0;
        write_data    = '0;
        read_addr     = '0;
        build_table();
        repeat (16) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        rst_dram_ctrl = 1'b0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            name = $sformatf("%s[%0d]", stim[i].phase.name(), i);
            case (stim[i].phase)
                PH_AUDIO_LOAD, PH_VIDEO_FILL: begin
                    if (stim[i].phase == PH_VIDEO_FILL && !sample_load_complete) begin
                        wait (sample_load_complete);
                    end
                    send_write(stim[i].data, stim[i].last);
                    wr = wr_log.pop_front();
                    check_addr(name, stim[i].addr, wr.addr);
                    check_data(name, stim[i].data, wr.write_data);
                end
                PH_AUDIO_READ: begin
                    send_read_addr(stim[i].addr);
                    wait (aud_log.size() > 0);
                    ar = aud_log.pop_front();
                    check_audio(name, '{stim[i].addr, stim[i].data}, ar);
                end
                default: begin
                    @(negedge clk_dram_ctrl);
                    video_almost_full = 1'b0;
                    wait (vid_log.size() > 0);
                    vr = vid_log.pop_front();
                    check_data(name, stim[i].data, vr.data);
                    check_flag({name, " last"}, stim[i].last, vr.last);
                end
            endcase
        end
        // Hold back-pressure and let the outstanding reads drain
        @(negedge clk_dram_ctrl);
        video_almost_full = 1'b1;
        wait (pend_q.size() == 0);
        repeat (12) @(negedge clk_dram_ctrl);
        if (write_count != AUDIO_LEN + VIDEO_LEN) report_failure("write total does not match table");
        if (audio_count != AUDIO_LEN) report_failure("audio response total does not match table");
        if (read_count != resp_count) report_failure("reads issued and responses received differ");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/dram_traffic_pkg.sv
hdl/command_fifo.sv
hdl/traffic_generator.sv
hdl/response_router.sv
hdl/dram_traffic_top.sv
testbench/dram_traffic_checker.sv
testbench/tb_dram_traffic.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DRAM traffic generator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_dram_traffic \
    -Mdir obj_dir -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $SIM_LOG"
    exit 1
fi
